/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    ////////////////////////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////////////////////////
    typedef logic [31:0] word_t;       // Data or instruction word
    typedef logic [31:0] addr_t;       // Byte address
    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] seq_t;        // Retirement sequence number
    typedef logic [3:0]  stall_cnt_t;  // Saturating decode stall count
    typedef logic [2:0]  credit_t;

    // Trace records allowed in flight
    localparam credit_t TRACE_CREDITS = 3'd4;

    // Memory sizes in words
    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;

    ////////////////////////////////////////////////////////////
    // RV32I opcodes of the supported subset
    ////////////////////////////////////////////////////////////
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;  // ADD, SUB
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;  // ADDI
    localparam logic [6:0] OP_LOAD   = 7'b0000011;  // LW
    localparam logic [6:0] OP_STORE  = 7'b0100011;  // SW
    localparam logic [6:0] OP_BRANCH = 7'b1100011;  // BEQ

    typedef enum logic {
        alu_add,
        alu_sub
    } alu_op_t;

endpackage

`default_nettype wire

/* instr_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_mem import cpu_pkg::*; (
    input  logic  clk,
    input  addr_t addr,
    output word_t data
);

    word_t rom [IMEM_DEPTH];

    // Unused words decode as no-ops
    initial begin
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            rom[i] = '0;
        end
        $readmemh("program.hex", rom);
    end

    assign data = rom[addr[$clog2(IMEM_DEPTH)+1:2]];  // Word index from the byte address

endmodule

`default_nettype wire

/* data_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module data_mem import cpu_pkg::*; (
    input  logic  clk,
    input  logic  we,
    input  addr_t addr,
    input  word_t wdata,
    output word_t rdata
);

    word_t ram [DMEM_DEPTH];
    logic [$clog2(DMEM_DEPTH)-1:0] word_idx;

    // Word addressing only, low two bits ignored
    assign word_idx = addr[$clog2(DMEM_DEPTH)+1:2];

    initial begin
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            ram[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            ram[word_idx] <= wdata;
        end
    end

    assign rdata = ram[word_idx];  // Combinational read

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     we,
    input  reg_idx_t rd,
    input  word_t    wd
);

    word_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rs1_data = (rs1_idx == '0)             ? '0 :
                      (we && rd == rs1_idx)       ? wd :
                                                    regs[rs1_idx];

    assign rs2_data = (rs2_idx == '0)             ? '0 :
                      (we && rd == rs2_idx)       ? wd :
                                                    regs[rs2_idx];

endmodule

`default_nettype wire

/* hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    input  reg_idx_t id_rs1,
    input  reg_idx_t id_rs2,
    input  logic     id_uses_rs2,
    input  reg_idx_t ex_rd,
    input  logic     ex_we,
    input  reg_idx_t mem_rd,
    input  logic     mem_we,
    input  logic     ex_branch_taken,
    input  logic     trace_hold,
    output logic     stall,
    output logic     flush,
    output logic     freeze
);

    logic rs1_hit;
    logic rs2_hit;

    // Source register pending in execute or memory
    function automatic logic pending(input reg_idx_t src, input reg_idx_t rd_ex,
                                     input logic we_ex, input reg_idx_t rd_mem,
                                     input logic we_mem);
        logic hit;
        hit = (we_ex && rd_ex == src) || (we_mem && rd_mem == src);
        return (src != '0) && hit;
    endfunction

    assign rs1_hit = pending(id_rs1, ex_rd, ex_we, mem_rd, mem_we);
    assign rs2_hit = id_uses_rs2 && pending(id_rs2, ex_rd, ex_we, mem_rd, mem_we);

    // Write-back is covered by the register file bypass

    assign freeze = trace_hold;                            // Trace back-pressure wins
    assign flush  = ex_branch_taken && !freeze;
    assign stall  = (rs1_hit || rs2_hit) && !flush && !freeze;  // Flushed decode never stalls

endmodule

`default_nettype wire

/* pipe_core.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_core import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    output addr_t    imem_addr,
    input  word_t    imem_data,
    output addr_t    dmem_addr,
    output word_t    dmem_wdata,
    output logic     dmem_we,
    input  word_t    dmem_rdata,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output reg_idx_t id_rs1,
    output reg_idx_t id_rs2,
    output logic     id_uses_rs2,
    output reg_idx_t ex_rd,
    output logic     ex_we,
    output reg_idx_t mem_rd,
    output logic     mem_we,
    output logic     ex_branch_taken,
    input  logic     stall,
    input  logic     flush,
    input  logic     freeze,
    output logic     wb_valid,
    output addr_t    wb_pc,
    output word_t    wb_instr,
    output logic     wb_we,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    addr_t pc_q;
    logic if_id_valid;
    addr_t if_id_pc;
    word_t if_id_instr;
    logic [6:0] opcode;
    reg_idx_t id_rd;
    word_t id_imm;
    alu_op_t id_alu_op;
    logic id_we, id_reads_rs2, id_use_imm, id_is_load, id_is_store, id_is_branch;
    logic id_ex_valid;
    addr_t id_ex_pc;
    word_t id_ex_instr, id_ex_rs1, id_ex_rs2, id_ex_imm;
    reg_idx_t id_ex_rd;
    alu_op_t id_ex_alu_op;
    logic id_ex_we, id_ex_use_imm, id_ex_is_load, id_ex_is_store, id_ex_is_branch;
    word_t ex_operand_b, ex_result;
    addr_t ex_target;
    logic ex_mem_valid;
    addr_t ex_mem_pc;
    word_t ex_mem_instr, ex_mem_result, ex_mem_store_data;
    reg_idx_t ex_mem_rd;
    logic ex_mem_we, ex_mem_is_load, ex_mem_is_store;
    logic mem_wb_valid;
    addr_t mem_wb_pc;
    word_t mem_wb_instr, mem_wb_data;
    reg_idx_t mem_wb_rd;
    logic mem_wb_we;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////
    assign opcode  = if_id_instr[6:0];
    assign id_rd   = if_id_instr[11:7];
    assign rs1_idx = if_id_instr[19:15];
    assign rs2_idx = if_id_instr[24:20];

    always_comb begin
        id_we        = 1'b0;
        id_reads_rs2 = 1'b0;
        id_use_imm   = 1'b0;
        id_is_load   = 1'b0;
        id_is_store  = 1'b0;
        id_is_branch = 1'b0;
        id_alu_op    = alu_add;
        id_imm       = {{20{if_id_instr[31]}}, if_id_instr[31:20]};  // I-type
        case (opcode)
            OP_RTYPE: begin
                id_we        = 1'b1;
                id_reads_rs2 = 1'b1;
                id_alu_op    = if_id_instr[30] ? alu_sub : alu_add;
            end
            OP_ITYPE: begin
                id_we      = 1'b1;
                id_use_imm = 1'b1;
            end
            OP_LOAD: begin
                id_we      = 1'b1;
                id_use_imm = 1'b1;
                id_is_load = 1'b1;
            end
            OP_STORE: begin
                id_reads_rs2 = 1'b1;
                id_use_imm   = 1'b1;
                id_is_store  = 1'b1;
                id_imm       = {{20{if_id_instr[31]}}, if_id_instr[31:25], if_id_instr[11:7]};
            end
            OP_BRANCH: begin
                id_reads_rs2 = 1'b1;
                id_is_branch = 1'b1;
                id_imm       = {{19{if_id_instr[31]}}, if_id_instr[31], if_id_instr[7],
                                if_id_instr[30:25], if_id_instr[11:8], 1'b0};
            end
            default: ;  // Anything else runs as a no-op
        endcase
        if (id_rd == '0) id_we = 1'b0;
    end

    // Bubbles never ask for a stall
    assign id_rs1      = if_id_valid ? rs1_idx : '0;
    assign id_rs2      = if_id_valid ? rs2_idx : '0;
    assign id_uses_rs2 = if_id_valid && id_reads_rs2;

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////
    assign ex_operand_b    = id_ex_use_imm ? id_ex_imm : id_ex_rs2;
    assign ex_result       = (id_ex_alu_op == alu_sub) ? id_ex_rs1 - ex_operand_b
                                                       : id_ex_rs1 + ex_operand_b;
    assign ex_target       = id_ex_pc + id_ex_imm;
    assign ex_branch_taken = id_ex_valid && id_ex_is_branch && (id_ex_rs1 == id_ex_rs2);
    assign ex_rd  = id_ex_rd;
    assign ex_we  = id_ex_valid && id_ex_we;
    assign mem_rd = ex_mem_rd;
    assign mem_we = ex_mem_valid && ex_mem_we;

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q         <= '0;
            if_id_valid  <= 1'b0;
            id_ex_valid  <= 1'b0;
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
        end else if (!freeze) begin
            if (flush) pc_q <= ex_target;      // Target fetched next cycle
            else if (!stall) pc_q <= pc_q + 32'd4;
            if (flush) if_id_valid <= 1'b0;
            else if (!stall) if_id_valid <= 1'b1;
            id_ex_valid  <= if_id_valid && !stall && !flush;  // Bubble on stall or flush
            ex_mem_valid <= id_ex_valid;
            mem_wb_valid <= ex_mem_valid;
        end
    end

    // Payload moves with the valid bits
    always_ff @(posedge clk) begin
        if (!freeze) begin
            if (!stall) begin
                if_id_pc    <= pc_q;
                if_id_instr <= imem_data;
            end
            id_ex_pc        <= if_id_pc;
            id_ex_instr     <= if_id_instr;
            id_ex_rs1       <= rs1_data;
            id_ex_rs2       <= rs2_data;
            id_ex_imm       <= id_imm;
            id_ex_rd        <= id_rd;
            id_ex_we        <= id_we;
            id_ex_alu_op    <= id_alu_op;
            id_ex_use_imm   <= id_use_imm;
            id_ex_is_load   <= id_is_load;
            id_ex_is_store  <= id_is_store;
            id_ex_is_branch <= id_is_branch;
            ex_mem_pc         <= id_ex_pc;
            ex_mem_instr      <= id_ex_instr;
            ex_mem_result     <= ex_result;
            ex_mem_store_data <= id_ex_rs2;
            ex_mem_rd         <= id_ex_rd;
            ex_mem_we         <= id_ex_we;
            ex_mem_is_load    <= id_ex_is_load;
            ex_mem_is_store   <= id_ex_is_store;
            mem_wb_pc    <= ex_mem_pc;
            mem_wb_instr <= ex_mem_instr;
            mem_wb_data  <= ex_mem_is_load ? dmem_rdata : ex_mem_result;
            mem_wb_rd    <= ex_mem_rd;
            mem_wb_we    <= ex_mem_we;
        end
    end

    assign imem_addr  = pc_q;
    assign dmem_addr  = ex_mem_result;
    assign dmem_wdata = ex_mem_store_data;
    assign dmem_we    = ex_mem_valid && ex_mem_is_store && !freeze;

    assign wb_valid = mem_wb_valid;
    assign wb_pc    = mem_wb_pc;
    assign wb_instr = mem_wb_instr;
    assign wb_we    = mem_wb_valid && mem_wb_we && !freeze;  // No write while frozen
    assign wb_rd    = mem_wb_rd;
    assign wb_data  = mem_wb_data;

endmodule

`default_nettype wire

/* retire_trace.sv */
`timescale 1ns/1ns
`default_nettype none

module retire_trace import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       stall,
    input  logic       flush,
    input  logic       freeze,
    input  logic       wb_valid,
    input  addr_t      wb_pc,
    input  word_t      wb_instr,
    input  logic       wb_we,
    input  reg_idx_t   wb_rd,
    input  word_t      wb_data,
    output logic       trace_valid,
    output seq_t       trace_seq,
    output addr_t      trace_pc,
    output word_t      trace_instr,
    output logic       trace_rd_we,
    output reg_idx_t   trace_rd,
    output word_t      trace_rd_data,
    output stall_cnt_t trace_stalls,
    input  logic       trace_credit,
    output logic       trace_hold
);

    stall_cnt_t id_slot, ex_slot, mem_slot, wb_slot;
    seq_t seq_q;
    credit_t credits_q;

    ////////////////////////////////////////////////////////////
    // Shadow stall counts, one slot per stage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            id_slot  <= '0;
            ex_slot  <= '0;
            mem_slot <= '0;
            wb_slot  <= '0;
        end else if (!freeze) begin  // Frozen cycles leave every slot alone
            if (stall) begin
                if (id_slot != '1) id_slot <= id_slot + 4'd1;  // Saturates
                ex_slot <= '0;
            end else if (flush) begin
                id_slot <= '0;
                ex_slot <= '0;
            end else begin
                id_slot <= '0;       // Fresh fetch enters decode
                ex_slot <= id_slot;
            end
            mem_slot <= ex_slot;
            wb_slot  <= mem_slot;
        end
    end

    // Retirement happens in the cycle write-back actually commits
    assign trace_valid   = wb_valid && !freeze;
    assign trace_seq     = seq_q;
    assign trace_pc      = wb_pc;
    assign trace_instr   = wb_instr;
    assign trace_rd_we   = wb_we;
    assign trace_rd      = wb_rd;
    assign trace_rd_data = wb_data;
    assign trace_stalls  = wb_slot;

    ////////////////////////////////////////////////////////////
    // Sequence number and credits
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_q     <= '0;
            credits_q <= TRACE_CREDITS;
        end else begin
            if (trace_valid) seq_q <= seq_q + 16'd1;
            case ({trace_valid, trace_credit})
                2'b10:   credits_q <= credits_q - 3'd1;
                2'b01:   credits_q <= credits_q + 3'd1;
                default: ;  // Use and return cancel
            endcase
        end
    end

    assign trace_hold = (credits_q == '0);

endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       trace_credit,
    output logic       trace_valid,
    output seq_t       trace_seq,
    output addr_t      trace_pc,
    output word_t      trace_instr,
    output logic       trace_rd_we,
    output reg_idx_t   trace_rd,
    output word_t      trace_rd_data,
    output stall_cnt_t trace_stalls,
    output logic       trace_hold
);

    addr_t imem_addr, dmem_addr, wb_pc;
    word_t imem_data, dmem_wdata, dmem_rdata, rs1_data, rs2_data, wb_instr, wb_data;
    reg_idx_t rs1_idx, rs2_idx, id_rs1, id_rs2, ex_rd, mem_rd, wb_rd;
    logic dmem_we, id_uses_rs2, ex_we, mem_we, ex_branch_taken;
    logic stall, flush, freeze, wb_valid, wb_we;

    pipe_core core_i (
        .clk, .rst, .imem_addr, .imem_data, .dmem_addr, .dmem_wdata, .dmem_we,
        .dmem_rdata, .rs1_idx, .rs2_idx, .rs1_data, .rs2_data, .id_rs1, .id_rs2,
        .id_uses_rs2, .ex_rd, .ex_we, .mem_rd, .mem_we, .ex_branch_taken,
        .stall, .flush, .freeze, .wb_valid, .wb_pc, .wb_instr, .wb_we, .wb_rd, .wb_data
    );

    instr_mem imem_i (.clk, .addr(imem_addr), .data(imem_data));

    data_mem dmem_i (.clk, .we(dmem_we), .addr(dmem_addr), .wdata(dmem_wdata),
                     .rdata(dmem_rdata));

    reg_file regs_i (.clk, .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
                     .we(wb_we), .rd(wb_rd), .wd(wb_data));

    hazard_unit hazard_i (
        .id_rs1, .id_rs2, .id_uses_rs2, .ex_rd, .ex_we, .mem_rd, .mem_we,
        .ex_branch_taken, .trace_hold, .stall, .flush, .freeze
    );

    retire_trace trace_i (
        .clk, .rst, .stall, .flush, .freeze, .wb_valid, .wb_pc, .wb_instr, .wb_we,
        .wb_rd, .wb_data, .trace_valid, .trace_seq, .trace_pc, .trace_instr,
        .trace_rd_we, .trace_rd, .trace_rd_data, .trace_stalls, .trace_credit,
        .trace_hold
    );

endmodule

`default_nettype wire

/* tb_cpu_top_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_top_sva import cpu_pkg::*; (
    input wire logic    clk,
    input wire logic    rst,
    input wire logic    trace_valid,
    input wire logic    trace_credit,
    input wire logic    trace_hold,
    input wire credit_t credits_q
);

    ////////////////////////////////////////////////////////////
    // Credit protocol
    ////////////////////////////////////////////////////////////
    // One credit per record, one back per return pulse
    a_credit_count: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> credits_q == $past(credits_q) - credit_t'($past(trace_valid))
                              + credit_t'($past(trace_credit)))
        else $error("credit counter does not follow records and returns");

    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits_q <= TRACE_CREDITS)
        else $error("credit counter above its limit");

    // No record leaves without a credit
    a_no_valid_on_hold: assert property (@(posedge clk) disable iff (rst)
        trace_hold |-> !trace_valid)
        else $error("trace record emitted while held");

    a_hold_stays: assert property (@(posedge clk) disable iff (rst)
        trace_hold && !trace_credit |=> trace_hold)
        else $error("trace_hold dropped without a credit return");

    a_hold_releases: assert property (@(posedge clk) disable iff (rst)
        trace_hold && trace_credit |=> !trace_hold)
        else $error("trace_hold stuck after a credit return");

endmodule

bind retire_trace tb_cpu_top_sva sva_i (.*);

`default_nettype wire

/* tb_cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_top import cpu_pkg::*;;

    logic clk = 1'b0;
    logic rst;
    logic trace_credit;
    logic trace_valid, trace_rd_we, trace_hold;
    seq_t trace_seq;
    addr_t trace_pc;
    word_t trace_instr, trace_rd_data;
    reg_idx_t trace_rd;
    stall_cnt_t trace_stalls;

    int seed = 32'h610f;
    int errors = 0;
    int records = 0;
    int outstanding = 0;  // Records not yet paid back with a credit
    logic credit_on = 1'b0;
    logic timed_out = 1'b0;

    // ISA model state
    word_t prog [IMEM_DEPTH];
    word_t mregs [32];
    word_t mmem [DMEM_DEPTH];
    seq_t exp_seq;
    addr_t exp_pc;
    int last_exit, p1_exit, p2_exit;
    logic last_taken;
    reg_idx_t p1_rd, p2_rd;

    // Expectations for the record on the trace port
    logic [6:0] op;
    reg_idx_t rd, rs1, rs2;
    word_t a, b, imm_i, imm_s, imm_b, exp_data, exp_instr;
    logic exp_we, uses2, is_store, taken;
    addr_t next_pc;
    int entry, ready, exp_stalls;

    cpu_top cpu_top_i (.*);

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    always_comb begin
        exp_instr = prog[exp_pc[$clog2(IMEM_DEPTH)+1:2]];
        op = trace_instr[6:0];
        rd = trace_instr[11:7];
        rs1 = trace_instr[19:15];
        rs2 = trace_instr[24:20];
        a = mregs[rs1];
        b = mregs[rs2];
        imm_i = {{20{trace_instr[31]}}, trace_instr[31:20]};
        imm_s = {{20{trace_instr[31]}}, trace_instr[31:25], trace_instr[11:7]};
        imm_b = {{19{trace_instr[31]}}, trace_instr[31], trace_instr[7],
                 trace_instr[30:25], trace_instr[11:8], 1'b0};
        uses2 = (op == OP_RTYPE) || (op == OP_STORE) || (op == OP_BRANCH);
        is_store = (op == OP_STORE);
        taken = (op == OP_BRANCH) && (a == b);
        exp_we = (op == OP_RTYPE || op == OP_ITYPE || op == OP_LOAD) && rd != '0;
        case (op)
            OP_RTYPE: exp_data = trace_instr[30] ? a - b : a + b;
            OP_LOAD:  exp_data = mmem[(a + imm_i) >> 2];
            default:  exp_data = a + imm_i;
        endcase
        next_pc = taken ? trace_pc + imm_b : trace_pc + 32'd4;
        // Decode entry cycle, then wait for producers to reach write-back
        entry = last_exit + 1 + (last_taken ? 2 : 0);
        ready = entry;
        if (p1_rd != '0 && (p1_rd == rs1 || (uses2 && p1_rd == rs2)) && p1_exit + 3 > ready)
            ready = p1_exit + 3;
        if (p2_rd != '0 && (p2_rd == rs1 || (uses2 && p2_rd == rs2)) && p2_exit + 3 > ready)
            ready = p2_exit + 3;
        exp_stalls = ready - entry;
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) mregs[i] <= '0;
            for (int i = 0; i < DMEM_DEPTH; i++) mmem[i] <= '0;
            exp_seq <= '0;
            exp_pc <= '0;
            last_exit <= -1;
            last_taken <= 1'b0;
            p1_rd <= '0;
            p2_rd <= '0;
            p1_exit <= 0;
            p2_exit <= 0;
        end else if (trace_valid) begin
            records <= records + 1;
            exp_seq <= exp_seq + 16'd1;
            exp_pc <= next_pc;
            if (exp_we) mregs[rd] <= exp_data;
            if (is_store) mmem[(a + imm_s) >> 2] <= b;
            last_exit <= ready;
            last_taken <= taken;
            p2_rd <= p1_rd;
            p2_exit <= p1_exit;
            p1_rd <= exp_we ? rd : '0;
            p1_exit <= ready;
        end
    end

    ////////////////////////////////////////////////////////////
    // Credit return
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) outstanding <= 0;
        else outstanding <= outstanding + int'(trace_valid) - int'(trace_credit);
    end

    always @(negedge clk) begin
        trace_credit <= 1'b0;
        if (!rst && credit_on && outstanding > 0 && ($random(seed) & 3) == 0)
            trace_credit <= 1'b1;
    end

    task automatic record_fail(input string name, input word_t got, input word_t exp);
        errors++;
        $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    a_reset: assert property (@(posedge clk) $fell(rst) |-> !trace_valid && !trace_hold)
        else record_fail("trace_valid/trace_hold",
                         {$sampled(trace_valid), $sampled(trace_hold)}, 0);
    a_seq: assert property (@(posedge clk) disable iff (rst) trace_valid |-> trace_seq == exp_seq)
        else record_fail("trace_seq", $sampled(trace_seq), $sampled(exp_seq));
    a_pc: assert property (@(posedge clk) disable iff (rst) trace_valid |-> trace_pc == exp_pc)
        else record_fail("trace_pc", $sampled(trace_pc), $sampled(exp_pc));
    a_instr: assert property (@(posedge clk) disable iff (rst)
        trace_valid |-> trace_instr == exp_instr)
        else record_fail("trace_instr", $sampled(trace_instr), $sampled(exp_instr));
    a_we: assert property (@(posedge clk) disable iff (rst)
        trace_valid |-> trace_rd_we == exp_we)
        else record_fail("trace_rd_we", $sampled(trace_rd_we), $sampled(exp_we));
    a_rd: assert property (@(posedge clk) disable iff (rst)
        trace_valid && exp_we |-> trace_rd == rd)
        else record_fail("trace_rd", $sampled(trace_rd), $sampled(rd));
    a_rd_data: assert property (@(posedge clk) disable iff (rst)
        trace_valid && exp_we |-> trace_rd_data == exp_data)
        else record_fail("trace_rd_data", $sampled(trace_rd_data), $sampled(exp_data));
    a_stalls: assert property (@(posedge clk) disable iff (rst)
        trace_valid |-> int'(trace_stalls) == exp_stalls)
        else record_fail("trace_stalls", $sampled(trace_stalls), $sampled(exp_stalls));
    a_hold: assert property (@(posedge clk) disable iff (rst)
        trace_hold == (outstanding == int'(TRACE_CREDITS)))
        else record_fail("trace_hold", $sampled(trace_hold), $sampled(outstanding == 4));

    task automatic report_timeout(input string reason);
        errors++;
        timed_out = 1'b1;
        $display("Timeout: %s", reason);
    endtask

    task automatic wait_records(input int target, input int limit);
        int n;
        n = 0;
        while (records < target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (records < target) report_timeout("trace records stopped arriving");
    endtask

    // At least one edge, so a credit granted before the stop has landed
    task automatic wait_hold(input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!trace_hold && n < limit);
        if (!trace_hold) report_timeout("trace_hold never rose with credits withheld");
    endtask

    task automatic run_phases();
        int held;
        credit_on <= 1'b1;  // Random credit return
        wait_records(25, 3000);
        if (!timed_out) begin
            $display("Test random credits done, %0d records", records);
            credit_on <= 1'b0;
            wait_hold(200);
        end
        if (!timed_out) begin
            held = records;
            repeat (30) @(negedge clk);
            a_held: assert (records == held)
                else record_fail("records", records, held);
            $display("Test withheld credits done, %0d records", records);
            credit_on <= 1'b1;
            wait_records(60, 4000);
        end
        if (!timed_out) begin
            $display("Test resumed credits done, %0d records", records);
        end
    endtask

    initial begin
        $readmemh("program.hex", prog);
        rst = 1'b1;
        trace_credit = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk) rst <= 1'b0;

        run_phases();

        $display("Records %0d, failures %0d", records, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
cpu_pkg.sv
instr_mem.sv
data_mem.sv
reg_file.sv
hazard_unit.sv
pipe_core.sv
retire_trace.sv
cpu_top.sv
tb_cpu_top_sva.sv
tb_cpu_top.sv

/* program.hex */
// One instruction word per line in hex, word 0 at byte address 0
// Assembly of each word in the comment after it
00500093  // 00 addi x1, x0, 5
00308113  // 04 addi x2, x1, 3    distance 1 on x1
002081B3  // 08 add  x3, x1, x2   distance 1 on x2
00700213  // 0c addi x4, x0, 7
404182B3  // 10 sub  x5, x3, x4   distance 1 on x4, 2 on x3
00100313  // 14 addi x6, x0, 1
00200393  // 18 addi x7, x0, 2
00530433  // 1c add  x8, x6, x5   distance 2 on x6, 3 on x5
00302423  // 20 sw   x3, 8(x0)
00802483  // 24 lw   x9, 8(x0)
00148533  // 28 add  x10, x9, x1  load at distance 1
00208463  // 2c beq  x1, x2, +8   not taken
00900593  // 30 addi x11, x0, 9
00348463  // 34 beq  x9, x3, +8   taken
06300613  // 38 addi x12, x0, 99  flushed
00A02623  // 3c sw   x10, 12(x0)
00C02683  // 40 lw   x13, 12(x0)
FFF68713  // 44 addi x14, x13, -1
40D707B3  // 48 sub  x15, x14, x13
00000063  // 4c beq  x0, x0, 0    spin here
